/* sim.f */
rtl/ps2_kbd_pkg.sv
rtl/seven_seg_hex.sv
rtl/ps2_frame_rx.sv
rtl/ps2_key_tracker.sv
rtl/ps2_display.sv
rtl/ps2_keyboard.sv
dv/ps2_keyboard_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the PS/2 keyboard testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -sv \
	--top-module ps2_keyboard_tb \
	-f sim.f \
	--Mdir obj_dir \
	-o ps2_keyboard_sim

# the log decides the result, so the simulator status does not stop the script
./obj_dir/ps2_keyboard_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0

/* dv/ps2_keyboard_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard_tb import ps2_kbd_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 400;
	localparam int HALF_BIT       = 10;  // clk cycles per keyboard clock half period
	localparam int READY_LIMIT    = 100; // cycles allowed for ready to respond
	localparam int SETTLE_CYCLES  = 40;

	logic         clk;
	logic         rst;
	logic         ps2_clk;
	logic         ps2_data;
	logic         ready;
	seg_pattern_t seg0;
	seg_pattern_t seg1;
	seg_pattern_t seg6;
	seg_pattern_t seg7;

	// lit segments per hex digit from a to g
	string seg_letters [16] = '{
		"abcdef", "bc", "abdeg", "abcdg", "bcfg", "acdfg", "acdefg", "abc",
		"abcdefg", "abcdfg", "abcefg", "cdefg", "adef", "bcdeg", "adefg", "aefg"
	};
	seg_pattern_t seg_ref [16];

	// expected state of the display
	logic         exp_ready;
	scan_code_t   exp_code;
	press_count_t exp_count;

	integer       seed;

	ps2_keyboard #(
		.FRAME_TIMEOUT (TIMEOUT_CYCLES)
	) uut (
		.clk      (clk),
		.rst      (rst),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.ready    (ready),
		.seg0     (seg0),
		.seg1     (seg1),
		.seg6     (seg6),
		.seg7     (seg7)
	);

	always #20 clk = ~clk;

	// active-low pattern from a list of lit segment letters
	function automatic seg_pattern_t letters_to_seg(input string lit);
		seg_pattern_t p;
		byte          ch;
		p = 8'hFF; // all dark including the dp
		for (int i = 0; i < lit.len(); i++) begin
			ch = lit.getc(i);
			p[3'd7 - 3'(ch - 8'h61)] = 1'b0; // a is bit 7
		end
		return p;
	endfunction

	task automatic build_seg_ref();
		for (int i = 0; i < 16; i++)
			seg_ref[i] = letters_to_seg(seg_letters[i]);
	endtask

	task automatic check_value(input string test, input string what,
			input logic [7:0] expected, input logic [7:0] actual);
		assert (actual === expected)
		else begin
			$display("Error: %s %s expected %h actual %h", test, what, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// compare every output with the model on the falling edge
	task automatic check_outputs(input string test);
		seg_pattern_t code_lo;
		seg_pattern_t code_hi;
		@(negedge clk);
		code_lo = exp_ready ? seg_ref[exp_code[3:0]] : 8'hFF;
		code_hi = exp_ready ? seg_ref[exp_code[7:4]] : 8'hFF;
		check_value(test, "ready", {7'd0, exp_ready}, {7'd0, ready});
		check_value(test, "seg0", code_lo, seg0);
		check_value(test, "seg1", code_hi, seg1);
		check_value(test, "seg6", seg_ref[exp_count[3:0]], seg6);
		check_value(test, "seg7", seg_ref[exp_count[7:4]], seg7);
	endtask

	task automatic wait_ready(input logic level, input string test);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (ready !== level && cnt < READY_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		assert (ready === level)
		else begin
			$display("%s timed out waiting for ready to become %b", test, level);
			$display("TEST RESULT: FAIL");
			$fatal(1, "ready timeout");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// drives one frame lsb first with data set while the keyboard clock is high
	task automatic send_frame(input scan_code_t code, input logic bad_start,
			input logic bad_parity, input logic bad_stop, input int num_bits);
		logic [10:0] frame;
		frame[0]   = bad_start;
		frame[8:1] = code;
		frame[9]   = ~(^code) ^ bad_parity; // odd parity
		frame[10]  = ~bad_stop;
		@(posedge clk);
		for (int i = 0; i < num_bits; i++) begin
			ps2_data <= frame[i];
			idle_cycles(HALF_BIT);
			ps2_clk <= 1'b0;
			idle_cycles(HALF_BIT);
			ps2_clk <= 1'b1;
		end
		idle_cycles(HALF_BIT);
		ps2_data <= 1'b1;
		idle_cycles(HALF_BIT);
	endtask

	task automatic press_key(input scan_code_t code, input string test);
		send_frame(code, 1'b0, 1'b0, 1'b0, 11);
		exp_ready = 1'b1;
		exp_code  = code;
		wait_ready(1'b1, test);
		check_outputs(test);
	endtask

	task automatic release_key(input scan_code_t code, input string test);
		send_frame(BREAK_PREFIX, 1'b0, 1'b0, 1'b0, 11);
		idle_cycles(SETTLE_CYCLES);
		check_outputs(test); // prefix alone changes nothing
		send_frame(code, 1'b0, 1'b0, 1'b0, 11);
		exp_ready = 1'b0;
		exp_count = exp_count + 8'd1;
		wait_ready(1'b0, test);
		check_outputs(test);
	endtask

	task automatic test_reset();
		check_outputs("test_reset");
	endtask

	task automatic test_make();
		press_key(8'h1C, "test_make");
	endtask

	task automatic test_break();
		release_key(8'h1C, "test_break");
	endtask

	task automatic test_bad_frames();
		send_frame(8'h3A, 1'b1, 1'b0, 1'b0, 11);
		idle_cycles(SETTLE_CYCLES);
		check_outputs("test_bad_frames start");
		send_frame(8'h3A, 1'b0, 1'b1, 1'b0, 11);
		idle_cycles(SETTLE_CYCLES);
		check_outputs("test_bad_frames parity");
		send_frame(8'h3A, 1'b0, 1'b0, 1'b1, 11);
		idle_cycles(SETTLE_CYCLES);
		check_outputs("test_bad_frames stop");
	endtask

	task automatic test_timeout();
		send_frame(8'h33, 1'b0, 1'b0, 1'b0, 6);
		idle_cycles(TIMEOUT_CYCLES + 100); // partial frame must be dropped
		check_outputs("test_timeout stall");
		press_key(8'h5A, "test_timeout");
	endtask

	task automatic test_random_keys();
		scan_code_t code;
		for (int n = 0; n < 20; n++) begin
			code = BREAK_PREFIX;
			while (code == BREAK_PREFIX)
				code = 8'($random(seed));
			press_key(code, "test_random_keys make");
			release_key(code, "test_random_keys break");
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		ps2_clk   = 1'b1;
		ps2_data  = 1'b1;
		seed      = 32'h842;
		exp_ready = 1'b0;
		exp_code  = 8'h00;
		exp_count = 8'h00;
		build_seg_ref();

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idle_cycles(2);

		test_reset();
		test_make();
		test_break();
		test_bad_frames();
		test_timeout();
		test_random_keys();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/ps2_keyboard.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard import ps2_kbd_pkg::*; #(
	parameter int FRAME_TIMEOUT = 4000 // clk cycles, about 80 us at 50 MHz
) (
	input  wire          clk,
	input  wire          rst,
	input  wire          ps2_clk,
	input  wire          ps2_data,
	output logic         ready,
	output seg_pattern_t seg0,
	output seg_pattern_t seg1,
	output seg_pattern_t seg6,
	output seg_pattern_t seg7
);

	scan_code_t   code;
	logic         code_valid;
	scan_code_t   last_code;
	logic         key_down;
	press_count_t release_count;

	ps2_frame_rx #(
		.FRAME_TIMEOUT (FRAME_TIMEOUT)
	) u_frame_rx (
		.clk        (clk),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.code       (code),
		.code_valid (code_valid)
	);

	ps2_key_tracker u_key_tracker (
		.clk           (clk),
		.rst           (rst),
		.code          (code),
		.code_valid    (code_valid),
		.last_code     (last_code),
		.key_down      (key_down),
		.release_count (release_count)
	);

	ps2_display u_display (
		.last_code     (last_code),
		.key_down      (key_down),
		.release_count (release_count),
		.seg0          (seg0),
		.seg1          (seg1),
		.seg6          (seg6),
		.seg7          (seg7)
	);

	assign ready = key_down; // high while a key is held

endmodule

`default_nettype wire

/* rtl/ps2_display.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_display import ps2_kbd_pkg::*; (
	input  scan_code_t   last_code,
	input  wire          key_down,
	input  press_count_t release_count,
	output seg_pattern_t seg0,
	output seg_pattern_t seg1,
	output seg_pattern_t seg6,
	output seg_pattern_t seg7
);

	hex_digit_t   code_lo;
	hex_digit_t   code_hi;
	hex_digit_t   cnt_lo;
	hex_digit_t   cnt_hi;
	seg_pattern_t code_lo_seg;
	seg_pattern_t code_hi_seg;

	assign code_lo = last_code[3:0];
	assign code_hi = last_code[7:4];
	assign cnt_lo  = release_count[3:0];
	assign cnt_hi  = release_count[7:4];

	seven_seg_hex u_dec_code_lo (
		.digit (code_lo),
		.seg   (code_lo_seg)
	);

	seven_seg_hex u_dec_code_hi (
		.digit (code_hi),
		.seg   (code_hi_seg)
	);

	// release count is always shown
	seven_seg_hex u_dec_cnt_lo (
		.digit (cnt_lo),
		.seg   (seg6)
	);

	seven_seg_hex u_dec_cnt_hi (
		.digit (cnt_hi),
		.seg   (seg7)
	);

	// all ones turns an active-low digit off
	assign seg0 = key_down ? code_lo_seg : '1;
	assign seg1 = key_down ? code_hi_seg : '1;

endmodule

`default_nettype wire

/* rtl/ps2_key_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_key_tracker import ps2_kbd_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  scan_code_t   code,
	input  wire          code_valid,
	output scan_code_t   last_code,
	output logic         key_down,
	output press_count_t release_count
);

	typedef enum logic {
		MAKE_WAIT,
		BREAK_WAIT
	} track_state_t;

	track_state_t state;
	logic         is_break;   // incoming code is the break prefix
	logic         take_make;  // incoming code is a new make code

	assign is_break  = (code == BREAK_PREFIX);
	assign take_make = code_valid && (state == MAKE_WAIT) && !is_break;

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= MAKE_WAIT;
			key_down      <= 1'b0;
			release_count <= '0;
		end else if (code_valid) begin
			unique case (state)
				MAKE_WAIT: begin
					if (is_break)
						state <= BREAK_WAIT; // outputs hold until the code follows
					else
						key_down <= 1'b1;
				end
				BREAK_WAIT: begin
					// whatever follows F0 is the released key
					key_down      <= 1'b0;
					release_count <= release_count + 1'b1; // wraps at 256
					state         <= MAKE_WAIT;
				end
				default: state <= MAKE_WAIT;
			endcase
		end
	end

	// last make code, kept through the break
	always_ff @(posedge clk) begin
		if (take_make)
			last_code <= code;
	end

endmodule

`default_nettype wire

/* rtl/ps2_frame_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_frame_rx import ps2_kbd_pkg::*; #(
	parameter int FRAME_TIMEOUT = 4000
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        ps2_clk,
	input  wire        ps2_data,
	output scan_code_t code,
	output logic       code_valid
);

	localparam int IDLE_W = $clog2(FRAME_TIMEOUT + 1);

	logic [1:0]        clk_sync;   // keyboard clock synchronizer
	logic              clk_prev;   // history flop for edge detect
	logic [1:0]        data_sync;  // keyboard data synchronizer
	logic              sample;     // falling edge seen on keyboard clock
	logic [10:0]       shreg;      // stop, parity, data[7:0], start
	logic [3:0]        bit_cnt;
	logic              frame_done; // eleventh bit went in last cycle
	logic [IDLE_W-1:0] idle_cnt;
	logic              idle_hit;

	always_ff @(posedge clk) begin
		clk_sync  <= {clk_sync[0], ps2_clk};
		clk_prev  <= clk_sync[1];
		data_sync <= {data_sync[0], ps2_data};
	end

	assign sample = clk_prev & ~clk_sync[1];

	// lsb arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (sample)
			shreg <= {data_sync[1], shreg[10:1]};
	end

	assign idle_hit = (idle_cnt == IDLE_W'(FRAME_TIMEOUT));

	// stall watchdog, restarted by every keyboard clock edge
	always_ff @(posedge clk) begin
		if (rst)
			idle_cnt <= '0;
		else if (sample)
			idle_cnt <= '0;
		else if (!idle_hit)
			idle_cnt <= idle_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (sample) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0; // good or bad, start over
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (idle_hit) begin
				bit_cnt <= '0; // keyboard stalled mid frame
			end
		end
	end

	// framing check on the complete frame
	// start low, stop high, odd parity over data and parity bit
	assign code_valid = frame_done && !shreg[0] && shreg[10] && (^shreg[9:1]);

	// stays stable until the next frame starts shifting
	assign code = shreg[8:1];

endmodule

`default_nettype wire

/* rtl/seven_seg_hex.sv */
`timescale 1ns/1ns
`default_nettype none

module seven_seg_hex import ps2_kbd_pkg::*; (
	input  hex_digit_t   digit,
	output seg_pattern_t seg
);

	seg_pattern_t seg_on; // lit segments, active high

	always_comb begin
		unique case (digit)
			4'h0: seg_on = 8'b11111100;
			4'h1: seg_on = 8'b01100000;
			4'h2: seg_on = 8'b11011010;
			4'h3: seg_on = 8'b11110010;
			4'h4: seg_on = 8'b01100110;
			4'h5: seg_on = 8'b10110110;
			4'h6: seg_on = 8'b10111110;
			4'h7: seg_on = 8'b11100000;
			4'h8: seg_on = 8'b11111110;
			4'h9: seg_on = 8'b11110110;
			4'ha: seg_on = 8'b11101110;
			4'hb: seg_on = 8'b00111110; // lower case b
			4'hc: seg_on = 8'b10011100;
			4'hd: seg_on = 8'b01111010; // lower case d
			4'he: seg_on = 8'b10011110;
			4'hf: seg_on = 8'b10001110;
			default: seg_on = 8'b00000000;
		endcase
	end

	// board digits light on a low level, dp stays dark
	assign seg = ~seg_on;

endmodule

`default_nettype wire

/* rtl/ps2_kbd_pkg.sv */
`default_nettype none

package ps2_kbd_pkg;

	// one scan code as received from the keyboard
	typedef logic [7:0] scan_code_t;

	// one nibble shown on a display digit
	typedef logic [3:0] hex_digit_t;

	// active-low digit pattern
	// bit 7 is segment a down to bit 1 for g, bit 0 is the dp
	typedef logic [7:0] seg_pattern_t;

	// key release count, wraps at 256
	typedef logic [7:0] press_count_t;

	// prefix sent ahead of the code of a released key
	localparam scan_code_t BREAK_PREFIX = 8'hF0;

endpackage

`default_nettype wire
